//--- contactTop.f
logic/fpPkg.sv
logic/contactPkg.sv
logic/floatAdd.sv
logic/floatCompare.sv
logic/contactDetect.sv
logic/candidateIngress.sv
logic/resultEgress.sv
logic/contactTop.sv
verif/clockGen.sv
verif/contactTop_props.sv
verif/contactTb.sv

//--- Makefile
TOP := contactTb

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f contactTop.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

//--- verif/contactTb.sv
`timescale 1ns/1ps
`default_nettype none

module contactTb;
  import contactPkg::*;

  localparam int IN_DEPTH        = 4;
  localparam int OUT_DEPTH       = 8;
  localparam int OUT_CREDITS     = 2;
  localparam int NUM_ROWS        = 18;
  localparam int GENERAL_ROWS    = 10;               // later rows are boundary cases
  localparam int WATCHDOG_CYCLES = 8 + NUM_ROWS * 40;
  localparam logic [31:0] EPS    = DEFAULT_EPSILON;  // 1e-8

  typedef struct packed {
    logic [31:0] u;
    logic [31:0] v;
    logic [31:0] det;
    logic        hit;
  } rowT;

  typedef struct packed {
    logic [31:0]      u;
    logic [31:0]      v;
    logic [31:0]      det;
    logic [TAG_W-1:0] tag;
  } candT;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             hit;
  } expT;

  // u, v, det, expected hit; dyadic values keep the truncated sum exact
  localparam rowT ROWS [NUM_ROWS] = '{
    '{32'h3e800000, 32'h3e800000, 32'h3f800000, 1'b1},  // .25 + .25
    '{32'h3f000000, 32'h3e800000, 32'h3f000000, 1'b1},  // sum .75
    '{32'h3e000000, 32'h3f400000, 32'h3f800000, 1'b1},  // sum .875
    '{32'h3f400000, 32'h3f000000, 32'h3f800000, 1'b0},  // sum 1.25
    '{32'h3f800000, 32'h3e000000, 32'h3f800000, 1'b0},  // sum 1.125
    '{32'h3fc00000, 32'h00000000, 32'h3f800000, 1'b0},  // u 1.5
    '{32'hbe800000, 32'h3f000000, 32'h3f800000, 1'b0},  // u -.25
    '{32'h3e800000, 32'h3e800000, 32'h00000000, 1'b0},  // det 0
    '{32'h3e800000, 32'h3f000000, 32'hbf800000, 1'b0},  // det -1
    '{32'h3ec00000, 32'h3f200000, 32'h3e800000, 1'b1},  // .375 + .625
    '{32'h00000000, 32'h3f000000, 32'h3f800000, 1'b1},  // u +0
    '{32'h80000000, 32'h3f000000, 32'h3f800000, 1'b1},  // u -0
    '{32'h3e800000, 32'h3f400000, 32'h3f800000, 1'b1},  // sum exactly 1
    '{32'h3f000000, 32'h3e800000, EPS,          1'b1},  // det equals epsilon
    '{32'h3f000000, 32'h3e800000, EPS - 32'd1,  1'b0},  // one ulp under epsilon
    '{32'h3f800001, 32'h00000000, 32'h3f800000, 1'b0},  // u one ulp over 1
    '{32'h3f000000, 32'hbe800000, 32'h3f800000, 1'b0},  // v -.25
    '{32'h3f800000, 32'h00000000, 32'h3f800000, 1'b1}   // u exactly 1
  };

  logic             clk;
  logic             rstN            = 1'b0;
  logic             inValid         = 1'b0;
  logic [31:0]      inU             = '0;
  logic [31:0]      inV             = '0;
  logic [31:0]      inDet           = '0;
  logic [TAG_W-1:0] inTag           = '0;
  logic             outCreditReturn = 1'b0;
  logic             inCredit;
  logic             outValid;
  logic             outHit;
  logic [TAG_W-1:0] outTag;

  candT             sendQ [$];        // waiting for a producer credit
  expT              expQ [$];         // results expected, in send order
  candT             cand;
  expT              expRes;
  logic [TAG_W-1:0] nextTag        = '0;
  int               seed           = 32'h7d4e2307;
  logic             running        = 1'b0;
  logic             consumerOn     = 1'b1;  // 0 withholds every credit
  logic             stallOn        = 1'b0;  // random credit stalls
  int               prodCredits    = IN_DEPTH;
  int               pendingReturns = 0;     // beats taken, credit not yet sent back
  int               sentTotal      = 0;
  int               creditPulses   = 0;
  int               beats          = 0;
  int               returns        = 0;
  int               errors         = 0;
  int               testErrBase    = 0;
  int               testsRun       = 0;
  int               testsFailed    = 0;

  clockGen #(.periodNs(8)) i_clk (.clk(clk));

  contactTop #(
    .epsilon(EPS), .inDepth(IN_DEPTH), .outDepth(OUT_DEPTH), .outCredits(OUT_CREDITS)
  ) i_dut (
    .clk(clk), .rstN(rstN),
    .inValid(inValid), .inU(inU), .inV(inV), .inDet(inDet), .inTag(inTag),
    .inCredit(inCredit),
    .outValid(outValid), .outTag(outTag), .outHit(outHit),
    .outCreditReturn(outCreditReturn)
  );

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("ERR %s got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic reportFailure(input string what);
    $display("%s", what);
    errors++;
  endtask

  function automatic int errorTotal();
    return errors + int'(i_dut.i_props.failCount);  // assertion failures count too
  endfunction

  task automatic queueRow(input int idx);
    candT c;
    expT  e;
    c.u   = ROWS[idx].u;
    c.v   = ROWS[idx].v;
    c.det = ROWS[idx].det;
    c.tag = nextTag;
    e.tag = nextTag;
    e.hit = ROWS[idx].hit;
    sendQ.push_back(c);
    expQ.push_back(e);
    nextTag++;
  endtask

  task automatic drain();
    while (sendQ.size() != 0 || expQ.size() != 0) @(posedge clk);
    repeat (2 * DETECT_LAT) @(posedge clk);  // a stray extra result would land here
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    if (errorTotal() == testErrBase) begin
      $display("test %s: ok", name);
    end else begin
      testsFailed++;
      $display("test %s: %0d errors", name, errorTotal() - testErrBase);
    end
    testErrBase = errorTotal();
  endtask

  // producer and consumer models, sample mid cycle and drive for the next edge
  always @(negedge clk) begin
    if (running) begin
      if (inCredit) begin
        prodCredits++;
        creditPulses++;
      end
      if (outValid) begin
        beats++;
        pendingReturns++;
        if (beats > OUT_CREDITS + returns) reportFailure("outValid beat beyond granted credits");
        if (expQ.size() == 0) begin
          reportFailure("result arrived with nothing expected");
        end else begin
          expRes = expQ.pop_front();
          checkValue("outTag", outTag, expRes.tag);
          checkValue("outHit", outHit, expRes.hit);
        end
      end
      outCreditReturn = 1'b0;
      if (consumerOn && pendingReturns > 0 && !(stallOn && ($random(seed) & 32'h3) == 0)) begin
        outCreditReturn = 1'b1;                 // one credit back per pulse
        pendingReturns--;
        returns++;
      end
      inValid = 1'b0;
      if (sendQ.size() != 0 && prodCredits > 0) begin
        cand    = sendQ.pop_front();
        inValid = 1'b1;                         // spends one credit
        inU     = cand.u;
        inV     = cand.v;
        inDet   = cand.det;
        inTag   = cand.tag;
        prodCredits--;
        sentTotal++;
      end
    end
  end

  initial begin
    int base;
    int pulseBase;
    int quiet;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    @(posedge clk);
    running = 1'b1;
    repeat (6) begin                            // nothing sent yet
      @(negedge clk);
      checkValue("outValid", outValid, 0);
      checkValue("inCredit", inCredit, 0);
    end
    finishTest("reset state");

    @(posedge clk);
    base = beats;
    for (int i = 0; i < GENERAL_ROWS; i++) queueRow(i);
    drain();
    checkValue("result count", beats - base, GENERAL_ROWS);
    finishTest("contact table");

    base = beats;
    for (int i = GENERAL_ROWS; i < NUM_ROWS; i++) queueRow(i);
    drain();
    checkValue("result count", beats - base, NUM_ROWS - GENERAL_ROWS);
    finishTest("boundaries");

    consumerOn = 1'b0;
    base       = sentTotal;
    pulseBase  = creditPulses;
    for (int i = 0; i < 20; i++) queueRow(i % NUM_ROWS);
    quiet = 0;
    while (quiet < 16) begin                    // producer starved for a while
      @(posedge clk);
      quiet = (prodCredits == 0) ? quiet + 1 : 0;
    end
    // both queues full plus what the initial consumer credits drained
    checkValue("accepted before stall", sentTotal - base, IN_DEPTH + OUT_DEPTH + OUT_CREDITS);
    if (creditPulses - pulseBase > sentTotal - base) begin
      reportFailure("more inCredit pulses than candidates sent");
    end
    consumerOn = 1'b1;
    drain();
    finishTest("upstream credits");

    stallOn = 1'b1;
    base    = beats;
    for (int i = 0; i < 2 * NUM_ROWS; i++) queueRow(i % NUM_ROWS);
    drain();
    checkValue("result count", beats - base, 2 * NUM_ROWS);
    stallOn = 1'b0;
    finishTest("downstream back-pressure");

    $display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errorTotal());
    if (errorTotal() == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout, run still busy after %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/contactTop_props.sv
`timescale 1ns/1ps
`default_nettype none

module contactTopProps #(
  parameter int inDepth    = 4,
  parameter int outCredits = 2
) (
  input logic clk,
  input logic rstN,
  input logic inValid,
  input logic inCredit,
  input logic issueValid,
  input logic hitValid,
  input logic outValid,
  input logic outCreditReturn
);
  import contactPkg::*;

  int                    inQueued;       // entries waiting in the input queue
  int                    egCredits;      // consumer credits egress should hold
  logic [DETECT_LAT-1:0] issueDly;       // issueValid history
  int unsigned           failCount = 0;  // failed assertions so far

  always_ff @(posedge clk) begin
    if (!rstN) begin
      inQueued  <= 0;
      egCredits <= outCredits;
      issueDly  <= '0;
    end else begin
      inQueued  <= inQueued + int'(inValid) - int'(inCredit);
      egCredits <= egCredits - int'(outValid) + int'(outCreditReturn);
      issueDly  <= {issueDly[DETECT_LAT-2:0], issueValid};
    end
  end

  // a push needs a free entry, a pop on the same edge frees one
  inQueueRoom: assert property (@(posedge clk) disable iff (!rstN)
    inValid |-> inQueued - int'(inCredit) < inDepth)
    else begin
      failCount = failCount + 1;
      $error("push into a full input queue");
    end

  outNeedsCredit: assert property (@(posedge clk) disable iff (!rstN)
    outValid |-> egCredits > 0)
    else begin
      failCount = failCount + 1;
      $error("outValid while egress holds no consumer credit");
    end

  // fixed pipe depth, no bubbles and no stalls
  detectLatency: assert property (@(posedge clk) disable iff (!rstN)
    hitValid == issueDly[DETECT_LAT-1])
    else begin
      failCount = failCount + 1;
      $error("hitValid not aligned with issueValid four cycles earlier");
    end

endmodule

bind contactTop contactTopProps #(.inDepth(inDepth), .outCredits(outCredits)) i_props (
  .clk(clk), .rstN(rstN), .inValid(inValid), .inCredit(inCredit),
  .issueValid(issueValid), .hitValid(hitValid), .outValid(outValid),
  .outCreditReturn(outCreditReturn)
);

`default_nettype wire

//--- verif/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter int periodNs = 8
) (
  output logic clk
);
  initial begin
    clk = 1'b0;                          // known level before the first edge
    forever #(periodNs / 2.0) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- logic/contactTop.sv
`timescale 1ns/1ps
`default_nettype none

module contactTop #(
  parameter logic [31:0] epsilon    = contactPkg::DEFAULT_EPSILON,
  parameter int          inDepth    = 4,   // producer credits after reset
  parameter int          outDepth   = 8,
  parameter int          outCredits = 2    // consumer credits after reset
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         inValid,
  input  logic [31:0]                  inU,
  input  logic [31:0]                  inV,
  input  logic [31:0]                  inDet,
  input  logic [contactPkg::TAG_W-1:0] inTag,
  output logic                         inCredit,
  output logic                         outValid,
  output logic [contactPkg::TAG_W-1:0] outTag,
  output logic                         outHit,
  input  logic                         outCreditReturn
);
  import contactPkg::*;

  logic             slotFree;
  logic             issueValid;
  logic [31:0]      issueU;
  logic [31:0]      issueV;
  logic [31:0]      issueDet;
  logic [TAG_W-1:0] issueTag;
  logic             hitValid;
  logic             hit;
  logic [TAG_W-1:0] hitTag;

  candidateIngress #(.inDepth(inDepth)) i_ingress (
    .clk(clk), .rstN(rstN),
    .inValid(inValid), .inU(inU), .inV(inV), .inDet(inDet), .inTag(inTag),
    .inCredit(inCredit), .slotFree(slotFree),
    .issueValid(issueValid), .issueU(issueU), .issueV(issueV),
    .issueDet(issueDet), .issueTag(issueTag)
  );

  contactDetect #(.epsilon(epsilon)) i_detect (
    .clk(clk), .rstN(rstN),
    .issueValid(issueValid), .issueU(issueU), .issueV(issueV),
    .issueDet(issueDet), .issueTag(issueTag),
    .hitValid(hitValid), .hit(hit), .hitTag(hitTag)
  );

  resultEgress #(.outDepth(outDepth), .outCredits(outCredits)) i_egress (
    .clk(clk), .rstN(rstN),
    .issueValid(issueValid), .slotFree(slotFree),
    .hitValid(hitValid), .hit(hit), .hitTag(hitTag),
    .outValid(outValid), .outHit(outHit), .outTag(outTag),
    .outCreditReturn(outCreditReturn)
  );

endmodule

`default_nettype wire

//--- logic/resultEgress.sv
`timescale 1ns/1ps
`default_nettype none

module resultEgress #(
  parameter int outDepth   = 8,
  parameter int outCredits = 2
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         issueValid,       // reserves one slot
  output logic                         slotFree,
  input  logic                         hitValid,
  input  logic                         hit,
  input  logic [contactPkg::TAG_W-1:0] hitTag,
  output logic                         outValid,
  output logic                         outHit,
  output logic [contactPkg::TAG_W-1:0] outTag,
  input  logic                         outCreditReturn   // consumer freed one entry
);
  import contactPkg::*;

  localparam int PTR_W = (outDepth > 1) ? $clog2(outDepth) : 1;
  localparam int CNT_W = $clog2(outDepth + 1);
  localparam int FLT_W = $clog2(DETECT_LAT + 1);  // in-flight never above pipe depth
  localparam int CR_W  = $clog2(outCredits + 1);

  logic [TAG_W-1:0] tagMem [outDepth];
  logic             hitMem [outDepth];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;        // results queued here
  logic [FLT_W-1:0] inFlight;     // issued, not yet back from detect
  logic [CNT_W:0]   occupied;
  logic [CR_W-1:0]  credits;      // consumer credits held

  assign occupied = count + inFlight;
  assign slotFree = occupied < outDepth;
  assign outValid = (count != '0) && (credits != '0);
  assign outTag   = tagMem[rdPtr];
  assign outHit   = hitMem[rdPtr];

  always_ff @(posedge clk) begin
    if (hitValid) begin
      tagMem[wrPtr] <= hitTag;
      hitMem[wrPtr] <= hit;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      inFlight <= '0;
      credits  <= CR_W'(outCredits);
    end else begin
      if (hitValid) begin
        wrPtr <= (wrPtr == PTR_W'(outDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (outValid) begin
        rdPtr <= (rdPtr == PTR_W'(outDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      count    <= count + CNT_W'(hitValid) - CNT_W'(outValid);
      inFlight <= inFlight + FLT_W'(issueValid) - FLT_W'(hitValid);  // reservation moves to queue
      credits  <= credits - CR_W'(outValid) + CR_W'(outCreditReturn);
    end
  end

endmodule

`default_nettype wire

//--- logic/candidateIngress.sv
`timescale 1ns/1ps
`default_nettype none

module candidateIngress #(
  parameter int inDepth = 4
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         inValid,   // producer holds a credit for this
  input  logic [31:0]                  inU,
  input  logic [31:0]                  inV,
  input  logic [31:0]                  inDet,
  input  logic [contactPkg::TAG_W-1:0] inTag,
  output logic                         inCredit,  // one pulse per entry leaving
  input  logic                         slotFree,  // egress has room reserved
  output logic                         issueValid,
  output logic [31:0]                  issueU,
  output logic [31:0]                  issueV,
  output logic [31:0]                  issueDet,
  output logic [contactPkg::TAG_W-1:0] issueTag
);
  import contactPkg::*;

  localparam int PTR_W = (inDepth > 1) ? $clog2(inDepth) : 1;
  localparam int CNT_W = $clog2(inDepth + 1);

  logic [31:0]      uMem   [inDepth];
  logic [31:0]      vMem   [inDepth];
  logic [31:0]      detMem [inDepth];
  logic [TAG_W-1:0] tagMem [inDepth];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             pop;

  assign pop        = (count != '0) && slotFree;  // newest write visible next cycle
  assign issueValid = pop;
  assign inCredit   = pop;                        // slot freed, hand credit back
  assign issueU     = uMem[rdPtr];
  assign issueV     = vMem[rdPtr];
  assign issueDet   = detMem[rdPtr];
  assign issueTag   = tagMem[rdPtr];

  always_ff @(posedge clk) begin
    if (inValid) begin
      uMem[wrPtr]   <= inU;
      vMem[wrPtr]   <= inV;
      detMem[wrPtr] <= inDet;
      tagMem[wrPtr] <= inTag;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (inValid) begin
        wrPtr <= (wrPtr == PTR_W'(inDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == PTR_W'(inDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      count <= count + CNT_W'(inValid) - CNT_W'(pop);
    end
  end

endmodule

`default_nettype wire

//--- logic/contactDetect.sv
`timescale 1ns/1ps
`default_nettype none

module contactDetect #(
  parameter logic [31:0] epsilon = contactPkg::DEFAULT_EPSILON
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         issueValid,
  input  logic [31:0]                  issueU,
  input  logic [31:0]                  issueV,
  input  logic [31:0]                  issueDet,
  input  logic [contactPkg::TAG_W-1:0] issueTag,
  output logic                         hitValid,  // DETECT_LAT after issueValid
  output logic                         hit,
  output logic [contactPkg::TAG_W-1:0] hitTag
);
  import fpPkg::*;
  import contactPkg::*;

  fpWord            uvSum;                     // u+v, ADD_LAT behind issue
  logic             uNeg;                      // each flag is a violation
  logic             vNeg;
  logic             detLow;
  logic             uOver;
  logic             sumOver;
  logic [3:0]       flagPipe [ADD_LAT];        // early flags wait for the sum
  logic [DETECT_LAT-1:0] validPipe;
  logic [TAG_W-1:0] tagPipe [DETECT_LAT];

  floatAdd i_add (
    .clk  (clk),
    .rstN (rstN),
    .en   (1'b1),      // free running, bubbles just flow through
    .a    (issueU),
    .b    (issueV),
    .sum  (uvSum)
  );

  floatCompare i_uZero   (.clk(clk), .rstN(rstN), .a(issueU),   .b(32'h0),  .lt(uNeg),   .gt());
  floatCompare i_vZero   (.clk(clk), .rstN(rstN), .a(issueV),   .b(32'h0),  .lt(vNeg),   .gt());
  floatCompare i_detEps  (.clk(clk), .rstN(rstN), .a(issueDet), .b(epsilon), .lt(detLow), .gt());
  floatCompare i_uOne    (.clk(clk), .rstN(rstN), .a(issueU),   .b(FP_ONE), .lt(),       .gt(uOver));
  floatCompare i_sumOne  (.clk(clk), .rstN(rstN), .a(uvSum),    .b(FP_ONE), .lt(),       .gt(sumOver));

  always_ff @(posedge clk) begin
    flagPipe[0] <= {uNeg, vNeg, detLow, uOver};  // valid one cycle after issue
    for (int i = 1; i < ADD_LAT; i++) begin
      flagPipe[i] <= flagPipe[i-1];
    end
    tagPipe[0] <= issueTag;
    for (int i = 1; i < DETECT_LAT; i++) begin
      tagPipe[i] <= tagPipe[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validPipe <= '0;
    end else begin
      validPipe <= {validPipe[DETECT_LAT-2:0], issueValid};
    end
  end

  assign hitValid = validPipe[DETECT_LAT-1];
  assign hitTag   = tagPipe[DETECT_LAT-1];
  assign hit      = ~(|flagPipe[ADD_LAT-1] | sumOver);  // contact when nothing violated

endmodule

`default_nettype wire

//--- logic/floatCompare.sv
`timescale 1ns/1ps
`default_nettype none

module floatCompare (
  input  logic         clk,
  input  logic         rstN,
  input  fpPkg::fpWord a,
  input  fpPkg::fpWord b,
  output logic         lt,  // a < b, one cycle later
  output logic         gt   // a > b, one cycle later
);
  import fpPkg::*;

  logic                         aZero;
  logic                         bZero;
  logic                         aNeg;   // sign ignored on zero, so -0 == +0
  logic                         bNeg;
  logic [FP_EXP_W+FP_MAN_W-1:0] aMag;
  logic [FP_EXP_W+FP_MAN_W-1:0] bMag;
  logic                         magLt;
  logic                         magGt;
  logic                         ltNext;
  logic                         gtNext;

  assign aZero = a.f.exp == '0;  // denormals flushed
  assign bZero = b.f.exp == '0;
  assign aNeg  = a.f.sign & ~aZero;
  assign bNeg  = b.f.sign & ~bZero;
  assign aMag  = aZero ? '0 : {a.f.exp, a.f.man};
  assign bMag  = bZero ? '0 : {b.f.exp, b.f.man};
  assign magLt = aMag < bMag;
  assign magGt = aMag > bMag;

  always_comb begin
    if (aNeg != bNeg) begin      // sign decides alone
      ltNext = aNeg;
      gtNext = bNeg;
    end else if (aNeg) begin     // both negative, larger magnitude is smaller
      ltNext = magGt;
      gtNext = magLt;
    end else begin
      ltNext = magLt;
      gtNext = magGt;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      lt <= 1'b0;
      gt <= 1'b0;
    end else begin
      lt <= ltNext;
      gt <= gtNext;
    end
  end

endmodule

`default_nettype wire

//--- logic/floatAdd.sv
`timescale 1ns/1ps
`default_nettype none

module floatAdd (
  input  logic         clk,
  input  logic         rstN,
  input  logic         en,   // advances all three stages
  input  fpPkg::fpWord a,
  input  fpPkg::fpWord b,
  output fpPkg::fpWord sum
);
  import fpPkg::*;

  localparam int MW   = FP_MAN_W + 1;     // mantissa incl hidden one
  localparam int LZ_W = $clog2(MW + 1);   // leading zero count, up to MW

  logic                aBig;              // |a| >= |b|
  fpWord               bigW;
  fpWord               smallW;
  logic [FP_EXP_W-1:0] expDiff;
  logic [MW-1:0]       bigMan;
  logic [MW-1:0]       smallMan;

  logic                s1Sign;            // stage 1, aligned operands
  logic                s1Sub;
  logic [FP_EXP_W-1:0] s1Exp;
  logic [MW-1:0]       s1ManBig;
  logic [MW-1:0]       s1ManSmall;

  logic                s2Sign;            // stage 2, raw mantissa sum
  logic [FP_EXP_W-1:0] s2Exp;
  logic [MW:0]         s2Man;             // extra bit for carry out

  logic [LZ_W-1:0]     lzCnt;
  logic [MW-1:0]       normMan;
  logic [FP_EXP_W-1:0] normExp;
  logic                normZero;

  // order by magnitude, exponent and fraction compare as one integer
  assign aBig     = {a.f.exp, a.f.man} >= {b.f.exp, b.f.man};
  assign bigW     = aBig ? a : b;
  assign smallW   = aBig ? b : a;
  assign expDiff  = bigW.f.exp - smallW.f.exp;
  assign bigMan   = (bigW.f.exp == '0) ? '0 : {1'b1, bigW.f.man};      // denormal -> 0
  assign smallMan = (smallW.f.exp == '0) ? '0 : {1'b1, smallW.f.man};

  always_ff @(posedge clk) begin
    if (en) begin
      s1Sign     <= bigW.f.sign;                  // result takes sign of larger
      s1Sub      <= a.f.sign ^ b.f.sign;          // unlike signs subtract
      s1Exp      <= bigW.f.exp;
      s1ManBig   <= bigMan;
      s1ManSmall <= (expDiff >= MW) ? '0 : (smallMan >> expDiff);  // shifted bits dropped
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      s2Sign <= s1Sign;
      s2Exp  <= s1Exp;
      if (s1Sub) begin
        s2Man <= {1'b0, s1ManBig} - {1'b0, s1ManSmall};  // never negative, big >= small
      end else begin
        s2Man <= {1'b0, s1ManBig} + {1'b0, s1ManSmall};
      end
    end
  end

  // leading zeros of the low MW bits, highest set bit wins
  always_comb begin
    lzCnt = LZ_W'(MW);
    for (int i = 0; i < MW; i++) begin
      if (s2Man[i]) begin
        lzCnt = LZ_W'(MW - 1 - i);
      end
    end
  end

  always_comb begin
    normZero = 1'b0;
    if (s2Man[MW]) begin                      // carry out, one step right
      normMan = s2Man[MW:1];
      normExp = s2Exp + 1'b1;
    end else begin
      normMan  = s2Man[MW-1:0] << lzCnt;
      normExp  = s2Exp - FP_EXP_W'(lzCnt);
      normZero = (s2Man == '0) || (s2Exp <= FP_EXP_W'(lzCnt));  // cancel or underflow
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      sum <= '0;
    end else if (en) begin
      sum.raw <= normZero ? '0 : {s2Sign, normExp, normMan[MW-2:0]};  // hidden one dropped
    end
  end

endmodule

`default_nettype wire

//--- logic/contactPkg.sv
`default_nettype none

package contactPkg;

  localparam int TAG_W = 8;  // candidate id carried beside the data

  // floatAdd stage count, sum ready this many cycles after inputs
  localparam int ADD_LAT = 3;

  // adder plus one registered compare on the sum
  localparam int DETECT_LAT = ADD_LAT + 1;

  // 1e-8 as single precision, lower bound on det
  localparam logic [31:0] DEFAULT_EPSILON = 32'h322bcc77;

endpackage

`default_nettype wire

//--- logic/fpPkg.sv
`default_nettype none

package fpPkg;

  localparam int FP_W        = 32;  // single precision word
  localparam int FP_EXP_W    = 8;   // biased exponent field
  localparam int FP_MAN_W    = 23;  // stored fraction, hidden one not kept
  localparam int FP_EXP_BIAS = 127;

  // field view of one float word, msb first
  typedef struct packed {
    logic                sign;  // 1 = negative
    logic [FP_EXP_W-1:0] exp;   // zero exponent treated as zero value
    logic [FP_MAN_W-1:0] man;
  } fpFields;

  // same 32 bits, read raw or as fields
  typedef union packed {
    logic [FP_W-1:0] raw;
    fpFields         f;
  } fpWord;

  // 1.0 is biased exponent with empty fraction
  localparam logic [FP_W-1:0] FP_ONE = {
    1'b0,
    FP_EXP_W'(FP_EXP_BIAS),
    {FP_MAN_W{1'b0}}
  };

endpackage

`default_nettype wire
